//--- source/llink_pkg.sv
/*
  Logic-link package for the memory-mapped master link.
  Holds the PHY word widths, the bit positions of markers and credits,
  the channel code enums and the packed logic-link channel structs.
*/
package llink_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int PHY_W = 160;
  localparam int AR_W  = 49;
  localparam int AW_W  = 49;
  localparam int W_W   = 77;
  localparam int R_W   = 71;
  localparam int B_W   = 6;
  localparam int PKT_W = 154;

  // TX word layout
  localparam int TX_MRK0_POS      = 78;
  localparam int TX_MRK1_POS      = 158;
  localparam int TX_R_CREDIT_POS  = 157;
  localparam int TX_B_CREDIT_POS  = 159;

  // RX word layout, markers are not decoded
  localparam int RX_MRK0_POS      = 79;
  localparam int RX_MRK1_POS      = 159;
  localparam int RX_AR_CREDIT_POS = 156;
  localparam int RX_AW_CREDIT_POS = 157;
  localparam int RX_W_CREDIT_POS  = 158;

  // Push bit inside the received packet
  localparam int R_PUSH_POS = 71;
  localparam int B_PUSH_POS = 6;

  //////////////////////////////////////////////////
  // Channel codes
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    CH_AR = 2'd0,
    CH_AW = 2'd1,
    CH_W  = 2'd2
  } tx_chan_e;

  typedef enum logic {
    RX_CH_B = 1'b0,
    RX_CH_R = 1'b1
  } rx_chan_e;

  //////////////////////////////////////////////////
  // Logic-link channel bundles
  //////////////////////////////////////////////////
  typedef struct packed {
    logic            push;
    logic [AR_W-1:0] data;
  } ar_llink_t;

  typedef struct packed {
    logic            push;
    logic [AW_W-1:0] data;
  } aw_llink_t;

  typedef struct packed {
    logic           push;
    logic [W_W-1:0] data;
  } w_llink_t;

  typedef struct packed {
    logic           push;
    logic           push_ovrd;
    logic [R_W-1:0] data;
  } r_llink_t;

  typedef struct packed {
    logic           push;
    logic           push_ovrd;
    logic [B_W-1:0] data;
  } b_llink_t;

  // Low means granted, FIFO may pop
  typedef struct packed {
    logic ar;
    logic aw;
    logic w;
  } tx_pop_t;

  typedef struct packed {
    logic ar;
    logic aw;
    logic w;
  } rx_credit_t;

  typedef struct packed {
    logic r;
    logic b;
  } tx_credit_t;

endpackage

//--- source/tx_llink_arbiter.sv
/*
  TX channel arbiter.
  Round-robin grant over the AR, AW and W push bits, with the pop
  override of each logic-link FIFO derived from the grant.
*/
`timescale 1ns/1ps

module tx_llink_arbiter
  import llink_pkg::*;
(
  input  logic     clk_rd,
  input  logic     rst_rd_n,
  input  logic     ar_push,
  input  logic     aw_push,
  input  logic     w_push,
  output tx_chan_e grant,
  output tx_pop_t  pop
);

  tx_chan_e ptr;
  logic     any_push;

  // Channel that follows c in AR, AW, W order
  function automatic tx_chan_e next_chan(input tx_chan_e c);
    case (c)
      CH_AR:   next_chan = CH_AW;
      CH_AW:   next_chan = CH_W;
      default: next_chan = CH_AR;
    endcase
  endfunction

  assign any_push = ar_push | aw_push | w_push;

  // First pushing channel at or after the pointer
  always_comb
  begin
    grant = CH_AR;
    case (ptr)
      CH_AW:
      begin
        if (aw_push) grant = CH_AW;
        else if (w_push) grant = CH_W;
        else if (ar_push) grant = CH_AR;
      end
      CH_W:
      begin
        if (w_push) grant = CH_W;
        else if (ar_push) grant = CH_AR;
        else if (aw_push) grant = CH_AW;
      end
      default:
      begin
        if (ar_push) grant = CH_AR;
        else if (aw_push) grant = CH_AW;
        else if (w_push) grant = CH_W;
      end
    endcase
  end

  // Pointer holds while idle
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
      ptr <= CH_AR;
    else if (any_push)
      ptr <= next_chan(grant);
  end

  assign pop.ar = (grant != CH_AR);
  assign pop.aw = (grant != CH_AW);
  assign pop.w  = (grant != CH_W);

endmodule

//--- source/tx_phy_framer.sv
/*
  TX PHY framer.
  Packs the granted channel word with its code, the two markers and the
  R and B return credits into the 160-bit PHY word, then registers it.
*/
`timescale 1ns/1ps

module tx_phy_framer
  import llink_pkg::*;
(
  input  logic             clk_rd,
  input  logic             rst_rd_n,
  input  tx_chan_e         grant,
  input  ar_llink_t        ar,
  input  aw_llink_t        aw,
  input  w_llink_t         w,
  input  logic [1:0]       mrk,
  input  tx_credit_t       credit,
  output logic [PHY_W-1:0] tx_phy0
);

  logic [PKT_W-1:0] packet;
  logic [PHY_W-1:0] phy_d;

  //////////////////////////////////////////////////
  // Packet of the granted channel
  //////////////////////////////////////////////////
  // Data, then push bit, then spare zeros
  always_comb
  begin
    case (grant)
      CH_AR:   packet = {{(PKT_W-AR_W-1){1'b0}}, ar.push, ar.data};
      CH_AW:   packet = {{(PKT_W-AW_W-1){1'b0}}, aw.push, aw.data};
      CH_W:    packet = {{(PKT_W-W_W-1){1'b0}}, w.push, w.data};
      default: packet = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // PHY word layout
  //////////////////////////////////////////////////
  always_comb
  begin
    phy_d = '0;
    phy_d[1:0] = grant;
    // Lower packet half sits below marker 0
    phy_d[TX_MRK0_POS-1:2] = packet[TX_MRK0_POS-3:0];
    phy_d[TX_MRK0_POS] = mrk[0];
    // Upper half runs up to the R credit
    phy_d[TX_R_CREDIT_POS-1:TX_MRK0_POS+1] = packet[PKT_W-1:TX_MRK0_POS-2];
    phy_d[TX_R_CREDIT_POS] = credit.r;
    phy_d[TX_MRK1_POS] = mrk[1];
    phy_d[TX_B_CREDIT_POS] = credit.b;
  end

  // Boundary flop
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
      tx_phy0 <= '0;
    else
      tx_phy0 <= phy_d;
  end

endmodule

//--- source/rx_phy_deframer.sv
/*
  RX PHY deframer.
  Registers the incoming PHY word, then splits it into the R and B
  logic-link outputs and the AR, AW and W credits.
*/
`timescale 1ns/1ps

module rx_phy_deframer
  import llink_pkg::*;
(
  input  logic             clk_rd,
  input  logic             rst_rd_n,
  input  logic [PHY_W-1:0] rx_phy0,
  output r_llink_t         r,
  output b_llink_t         b,
  output rx_credit_t       credit
);

  logic [PHY_W-1:0] rx_q;
  rx_chan_e         code;
  logic [PKT_W-1:0] packet;

  // Boundary flop
  always_ff @(posedge clk_rd or negedge rst_rd_n)
  begin
    if (!rst_rd_n)
      rx_q <= '0;
    else
      rx_q <= rx_phy0;
  end

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////
  assign code = rx_chan_e'(rx_q[0]);

  // Packet spans bits 1 to 155 around marker 0
  assign packet = {rx_q[RX_AR_CREDIT_POS-1:RX_MRK0_POS+1], rx_q[RX_MRK0_POS-1:1]};

  // Only the addressed channel may push
  assign r.push_ovrd = (code != RX_CH_R);
  assign b.push_ovrd = (code != RX_CH_B);

  assign r.push = (code == RX_CH_R) && packet[R_PUSH_POS];
  assign b.push = (code == RX_CH_B) && packet[B_PUSH_POS];

  // Data lanes follow the packet whatever the code
  assign r.data = packet[R_W-1:0];
  assign b.data = packet[B_W-1:0];

  assign credit.ar = rx_q[RX_AR_CREDIT_POS];
  assign credit.aw = rx_q[RX_AW_CREDIT_POS];
  assign credit.w  = rx_q[RX_W_CREDIT_POS];

endmodule

//--- source/axi_mm_master_link.sv
/*
  Memory-mapped bus master link.
  Concatenates the AR, AW and W logic links onto one 160-bit PHY word
  and splits the received word into R, B and credits.
*/
`timescale 1ns/1ps

module axi_mm_master_link
  import llink_pkg::*;
(
  input  logic             clk_rd,
  input  logic             rst_rd_n,

  // Logic-link side
  input  ar_llink_t        tx_ar,
  input  aw_llink_t        tx_aw,
  input  w_llink_t         tx_w,
  output tx_pop_t          tx_pop,
  input  tx_credit_t       tx_credit,
  input  logic [1:0]       tx_mrk_userbit,
  output r_llink_t         rx_r,
  output b_llink_t         rx_b,
  output rx_credit_t       rx_credit,

  // PHY side
  output logic [PHY_W-1:0] tx_phy0,
  input  logic [PHY_W-1:0] rx_phy0
);

  tx_chan_e grant;

  //////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////
  tx_llink_arbiter u_arb (
    .clk_rd   (clk_rd),
    .rst_rd_n (rst_rd_n),
    .ar_push  (tx_ar.push),
    .aw_push  (tx_aw.push),
    .w_push   (tx_w.push),
    .grant    (grant),
    .pop      (tx_pop)
  );

  // One cycle from grant to PHY word
  tx_phy_framer u_framer (
    .clk_rd   (clk_rd),
    .rst_rd_n (rst_rd_n),
    .grant    (grant),
    .ar       (tx_ar),
    .aw       (tx_aw),
    .w        (tx_w),
    .mrk      (tx_mrk_userbit),
    .credit   (tx_credit),
    .tx_phy0  (tx_phy0)
  );

  //////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////
  rx_phy_deframer u_deframer (
    .clk_rd   (clk_rd),
    .rst_rd_n (rst_rd_n),
    .rx_phy0  (rx_phy0),
    .r        (rx_r),
    .b        (rx_b),
    .credit   (rx_credit)
  );

endmodule

//--- sim/axi_mm_master_link_assertions.sv
/*
  Arbiter assertions.
  Checks the pop overrides of the TX arbiter against its push bits.
*/
`timescale 1ns/1ps

module axi_mm_master_link_assertions
  import llink_pkg::*;
(
  input logic    clk_rd,
  input logic    rst_rd_n,
  input logic    ar_push,
  input logic    aw_push,
  input logic    w_push,
  input tx_pop_t pop
);

  logic any_push;

  assign any_push = ar_push | aw_push | w_push;

  // At most one FIFO pops per cycle
  a_one_pop: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    $onehot0(~{pop.ar, pop.aw, pop.w}))
    else $error("more than one pop override is low");

  // Granted channel pushed, or the link is idle
  a_ar_pop: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    !pop.ar |-> (ar_push || !any_push))
    else $error("AR granted without a push");

  a_aw_pop: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    !pop.aw |-> (aw_push || !any_push))
    else $error("AW granted without a push");

  a_w_pop: assert property (@(posedge clk_rd) disable iff (!rst_rd_n)
    !pop.w |-> (w_push || !any_push))
    else $error("W granted without a push");

endmodule

bind tx_llink_arbiter axi_mm_master_link_assertions u_assertions (
  .clk_rd   (clk_rd),
  .rst_rd_n (rst_rd_n),
  .ar_push  (ar_push),
  .aw_push  (aw_push),
  .w_push   (w_push),
  .pop      (pop)
);

//--- sim/tb_axi_mm_master_link.sv
/*
  Testbench for the memory-mapped master link.
  Directed tests for arbitration, TX framing, markers and credits, and RX
  decode from a far-side PHY model, with a watchdog.
*/
`timescale 1ns/1ps

module tb_axi_mm_master_link
  import llink_pkg::*;
();

  localparam int N_RR  = 12;
  localparam int N_MRK = 8;
  localparam int N_RX  = 16;
  // Reset plus every test cycle, with some slack
  localparam int WATCH_CYCLES = 20 + 2 * N_RR + N_MRK + 2 * N_RX;

  logic             clk_rd;
  logic             rst_rd_n;
  ar_llink_t        tx_ar;
  aw_llink_t        tx_aw;
  w_llink_t         tx_w;
  tx_pop_t          tx_pop;
  tx_credit_t       tx_credit;
  logic [1:0]       tx_mrk_userbit;
  r_llink_t         rx_r;
  b_llink_t         rx_b;
  rx_credit_t       rx_credit;
  logic [PHY_W-1:0] tx_phy0;
  logic [PHY_W-1:0] rx_phy0;

  int seed      = 32'h066e9151;
  int errors    = 0;
  int checks    = 0;
  // Model of the arbiter pointer, 0 = AR, 1 = AW, 2 = W
  int ptr_model = 0;

  axi_mm_master_link DUT (
    .clk_rd         (clk_rd),
    .rst_rd_n       (rst_rd_n),
    .tx_ar          (tx_ar),
    .tx_aw          (tx_aw),
    .tx_w           (tx_w),
    .tx_pop         (tx_pop),
    .tx_credit      (tx_credit),
    .tx_mrk_userbit (tx_mrk_userbit),
    .rx_r           (rx_r),
    .rx_b           (rx_b),
    .rx_credit      (rx_credit),
    .tx_phy0        (tx_phy0),
    .rx_phy0        (rx_phy0)
  );

  initial
  begin
    clk_rd = 1'b0;
    forever #10 clk_rd = ~clk_rd;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [PHY_W-1:0] rand_bits();
    rand_bits = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // First requester at or after pointer p, AR when idle
  function automatic tx_chan_e pick_grant(input logic [2:0] req, input int p);
    int idx;
    pick_grant = CH_AR;
    for (int k = 2; k >= 0; k--)
    begin
      idx = (p + k) % 3;
      if (req[idx])
        pick_grant = tx_chan_e'(idx[1:0]);
    end
  endfunction

  function automatic logic [PKT_W-1:0] tx_packet(input tx_chan_e g, input ar_llink_t ar,
                                                 input aw_llink_t aw, input w_llink_t w);
    logic [PKT_W-1:0] pkt;
    pkt = '0;
    case (g)
      CH_AW:
      begin
        pkt[AW_W-1:0] = aw.data;
        pkt[AW_W] = aw.push;
      end
      CH_W:
      begin
        pkt[W_W-1:0] = w.data;
        pkt[W_W] = w.push;
      end
      default:
      begin
        pkt[AR_W-1:0] = ar.data;
        pkt[AR_W] = ar.push;
      end
    endcase
    return pkt;
  endfunction

  function automatic logic [PHY_W-1:0] tx_layout(input tx_chan_e code,
                                                 input logic [PKT_W-1:0] pkt,
                                                 input logic [1:0] mrk, input tx_credit_t cr);
    logic [PHY_W-1:0] word;
    word = '0;
    word[1:0] = code;
    for (int i = 0; i < PKT_W; i++)
    begin
      // Packet skips over marker 0
      if (i < TX_MRK0_POS - 2)
        word[i + 2] = pkt[i];
      else
        word[i + 3] = pkt[i];
    end
    word[TX_MRK0_POS] = mrk[0];
    word[TX_MRK1_POS] = mrk[1];
    word[TX_R_CREDIT_POS] = cr.r;
    word[TX_B_CREDIT_POS] = cr.b;
    return word;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_phy_word(input logic [PHY_W-1:0] got, input logic [PHY_W-1:0] exp,
                                input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_r(input r_llink_t got, input r_llink_t exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_b(input b_llink_t got, input b_llink_t exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_rx_credit(input rx_credit_t got, input rx_credit_t exp,
                                 input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic check_pop(input tx_pop_t got, input tx_pop_t exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers, called at a falling edge
  //////////////////////////////////////////////////
  task automatic tx_cycle(input ar_llink_t ar, input aw_llink_t aw, input w_llink_t w,
                          input logic [1:0] mrk, input tx_credit_t cr);
    tx_chan_e         g;
    tx_pop_t          exp_pop;
    logic [PHY_W-1:0] exp_word;
    logic [2:0]       req;
    req = {w.push, aw.push, ar.push};
    g = pick_grant(req, ptr_model);
    exp_pop.ar = (g != CH_AR);
    exp_pop.aw = (g != CH_AW);
    exp_pop.w = (g != CH_W);
    exp_word = tx_layout(g, tx_packet(g, ar, aw, w), mrk, cr);
    if (req != 3'b000)
      ptr_model = (int'(g) + 1) % 3;
    tx_ar = ar;
    tx_aw = aw;
    tx_w = w;
    tx_mrk_userbit = mrk;
    tx_credit = cr;
    #1;
    check_pop(tx_pop, exp_pop, "pop override");
    @(negedge clk_rd);
    check_phy_word(tx_phy0, exp_word, "tx word");
  endtask

  // Far-side PHY sends one word
  task automatic rx_cycle(input logic [PHY_W-1:0] word);
    logic [PKT_W-1:0] pkt;
    rx_chan_e         code;
    r_llink_t         exp_r;
    b_llink_t         exp_b;
    rx_credit_t       exp_cr;
    for (int i = 0; i < PKT_W; i++)
    begin
      if (i < RX_MRK0_POS - 1)
        pkt[i] = word[i + 1];
      else
        pkt[i] = word[i + 2];
    end
    code = rx_chan_e'(word[0]);
    exp_r.push_ovrd = (code != RX_CH_R);
    exp_r.push = (code == RX_CH_R) && pkt[R_PUSH_POS];
    exp_r.data = pkt[R_W-1:0];
    exp_b.push_ovrd = (code != RX_CH_B);
    exp_b.push = (code == RX_CH_B) && pkt[B_PUSH_POS];
    exp_b.data = pkt[B_W-1:0];
    exp_cr.ar = word[RX_AR_CREDIT_POS];
    exp_cr.aw = word[RX_AW_CREDIT_POS];
    exp_cr.w = word[RX_W_CREDIT_POS];
    rx_phy0 = word;
    @(negedge clk_rd);
    check_r(rx_r, exp_r, "rx r");
    check_b(rx_b, exp_b, "rx b");
    check_rx_credit(rx_credit, exp_cr, "rx credit");
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_reset_values();
    r_llink_t   exp_r;
    b_llink_t   exp_b;
    rx_credit_t exp_cr;
    exp_r = '0;
    exp_r.push_ovrd = 1'b1;
    exp_b = '0;
    exp_cr = '0;
    check_phy_word(tx_phy0, '0, "reset tx word");
    check_r(rx_r, exp_r, "reset rx r");
    check_b(rx_b, exp_b, "reset rx b");
    check_rx_credit(rx_credit, exp_cr, "reset rx credit");
  endtask

  task automatic test_single_channel();
    aw_llink_t aw;
    w_llink_t  w;
    logic [PHY_W-1:0] r;
    r = rand_bits();
    aw.push = 1'b1;
    aw.data = r[AW_W-1:0];
    tx_cycle('0, aw, '0, 2'b00, '0);
    r = rand_bits();
    w.push = 1'b1;
    w.data = r[W_W-1:0];
    tx_cycle('0, '0, w, 2'b00, '0);
  endtask

  task automatic test_round_robin();
    ar_llink_t ar;
    aw_llink_t aw;
    w_llink_t  w;
    logic [PHY_W-1:0] r;
    for (int n = 0; n < 2 * N_RR; n++)
    begin
      r = rand_bits();
      ar.push = 1'b1;
      ar.data = r[AR_W-1:0];
      aw.push = (n < N_RR);
      aw.data = r[AR_W +: AW_W];
      w.push = 1'b1;
      w.data = r[PHY_W-1 -: W_W];
      tx_cycle(ar, aw, w, 2'b00, '0);
    end
  endtask

  // Idle link, so the pointer holds
  task automatic test_markers_credits();
    ar_llink_t  ar;
    aw_llink_t  aw;
    w_llink_t   w;
    tx_credit_t cr;
    logic [PHY_W-1:0] r;
    // Move the pointer off AR first
    r = rand_bits();
    ar.push = 1'b1;
    ar.data = r[AR_W-1:0];
    tx_cycle(ar, '0, '0, 2'b00, '0);
    for (int n = 0; n < N_MRK; n++)
    begin
      r = rand_bits();
      ar.push = 1'b0;
      ar.data = r[AR_W-1:0];
      cr.r = r[100];
      cr.b = r[101];
      tx_cycle(ar, '0, '0, r[151:150], cr);
    end
    // Held pointer decides the next grant
    r = rand_bits();
    ar.push = 1'b1;
    ar.data = r[AR_W-1:0];
    aw.push = 1'b1;
    aw.data = r[AR_W +: AW_W];
    w.push = 1'b1;
    w.data = r[PHY_W-1 -: W_W];
    tx_cycle(ar, aw, w, 2'b00, '0);
  endtask

  task automatic test_rx_decode();
    logic [PHY_W-1:0] word;
    for (int n = 0; n < N_RX; n++)
    begin
      word = rand_bits();
      rx_cycle(word);
      // Same word with both markers flipped
      word[RX_MRK0_POS] = ~word[RX_MRK0_POS];
      word[RX_MRK1_POS] = ~word[RX_MRK1_POS];
      rx_cycle(word);
    end
  endtask

  initial
  begin
    rst_rd_n = 1'b0;
    tx_ar = '0;
    tx_aw = '0;
    tx_w = '0;
    tx_credit = '0;
    tx_mrk_userbit = 2'b00;
    rx_phy0 = '0;
    repeat (4) @(negedge clk_rd);
    rst_rd_n = 1'b1;
    test_reset_values();
    test_single_channel();
    test_round_robin();
    test_markers_credits();
    test_rx_decode();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCH_CYCLES * 20 + 400);
    $display("timeout: the tests did not finish within %0d cycles", WATCH_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

//--- src.f
source/llink_pkg.sv
source/tx_llink_arbiter.sv
source/tx_phy_framer.sv
source/rx_phy_deframer.sv
source/axi_mm_master_link.sv
sim/axi_mm_master_link_assertions.sv
sim/tb_axi_mm_master_link.sv

//--- Makefile
# Verilator build for the memory-mapped master link

TOP = tb_axi_mm_master_link

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

# The run passes only when the log holds the pass line
sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
